// ==== bench/axis_switch_assertions.sv ====
`timescale 1ns/1ps

module axis_switch_assertions
    import axis_switch_pkg::*;
(
    input logic         axis_clk,
    input logic         axi_reset_n,
    input grant_t       grant,
    input logic         frame_done,
    input arb_state_t   arb_state,
    input axis_tagged_t is_out,
    input logic         is_out_valid,
    input logic         is_out_ready,
    input logic         up_out_valid,
    input logic         aa_out_valid
);

    int fail_cnt;

    grant_onehot: assert property (@(posedge axis_clk) disable iff (!axi_reset_n)
        $onehot0(grant))
        else begin
            fail_cnt++;
            $error("grant is neither one-hot nor zero");
        end

    // Output register holds under back-pressure
    is_out_hold: assert property (@(posedge axis_clk) disable iff (!axi_reset_n)
        is_out_valid && !is_out_ready |=> is_out_valid && $stable(is_out))
        else begin
            fail_cnt++;
            $error("is_out changed while stalled");
        end

    one_dest: assert property (@(posedge axis_clk) disable iff (!axi_reset_n)
        !(up_out_valid && aa_out_valid))
        else begin
            fail_cnt++;
            $error("both downstream outputs valid");
        end

    grant_change: assert property (@(posedge axis_clk) disable iff (!axi_reset_n)
        $changed(grant) |-> ($past(arb_state) == ARB_IDLE) || $past(frame_done))
        else begin
            fail_cnt++;
            $error("grant changed inside a frame");
        end

endmodule

bind axis_switch axis_switch_assertions axis_switch_assertions_inst (
    .axis_clk     (axis_clk),
    .axi_reset_n  (axi_reset_n),
    .grant        (grant),
    .frame_done   (frame_done),
    .arb_state    (rr_arbiter_inst.state),
    .is_out       (is_out),
    .is_out_valid (is_out_valid),
    .is_out_ready (is_out_ready),
    .up_out_valid (up_out_valid),
    .aa_out_valid (aa_out_valid)
);

// ==== bench/axis_switch_tb.sv ====
`timescale 1ns/1ps

module axis_switch_tb
    import axis_switch_pkg::*;
();

    localparam logic [1:0] PH_SRC   = 2'd0;
    localparam logic [1:0] PH_SER   = 2'd1;
    localparam logic [1:0] PH_RUN   = 2'd2;
    localparam logic [1:0] PH_CHK   = 2'd3;
    localparam logic [1:0] RDY_ALL  = 2'd0;
    localparam logic [1:0] RDY_RAND = 2'd1;
    localparam logic [1:0] RDY_NONE = 2'd2;

    typedef struct packed {
        logic [1:0] phase;
        logic [1:0] sel;
        data_t      data;
        logic       last;
        logic [1:0] rdy;
    } row_t;

    logic axis_clk;
    logic axi_reset_n;
    axis_beat_t up_in, aa_in, la_in, up_out, aa_out;
    logic up_in_valid, aa_in_valid, la_in_valid, up_in_ready, aa_in_ready, la_in_ready;
    axis_tagged_t is_out, is_in;
    logic is_out_valid, is_out_ready, is_in_valid, is_in_ready;
    logic up_out_valid, up_out_ready, aa_out_valid, aa_out_ready;

    row_t         stim [128];
    int           n_rows;
    axis_beat_t   src_mem [N_SOURCES][16];
    int           src_wr [N_SOURCES];
    int           src_rd [N_SOURCES];
    int           mdl_rd [N_SOURCES];
    int           mdl_base;
    axis_tagged_t exp_up_q [$];
    axis_tagged_t ser_q [$];
    axis_beat_t   exp_dn_up [$];
    axis_beat_t   exp_dn_aa [$];
    int           occ;
    logic [31:0]  lfsr;
    int           err_up, err_dn, err_rdy, err_sva;
    int           cycle_cnt, max_cycles;

    axis_switch axis_switch_inst (.*);

    initial begin
        axis_clk = 1'b0;
        forever #2 axis_clk = ~axis_clk;
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic ready_value(input logic [1:0] mode, output logic r);
        case (mode)
            RDY_ALL: r = 1'b1;
            RDY_RAND: begin
                lfsr = lfsr_step(lfsr);
                r = lfsr[0];
            end
            default: r = 1'b0;
        endcase
    endtask

    function automatic axis_beat_t make_beat(input data_t data, input logic last);
        axis_beat_t b;
        b.data = data;
        b.strb = data[3:0];
        b.keep = data[7:4];
        b.last = last;
        b.user = data[9:8];
        return b;
    endfunction

    function automatic axis_beat_t src_head(input int s);
        if (src_rd[s] == src_wr[s]) begin
            return '0;
        end else begin
            return src_mem[s][src_rd[s]];
        end
    endfunction

    task automatic add_row(input logic [1:0] phase, input int sel, input logic last,
                           input logic [1:0] rdy);
        stim[n_rows] = '{phase, 2'(sel), 32'h5a00_0000 + (sel << 16) + n_rows * 37, last, rdy};
        n_rows++;
    endtask

    task automatic build_stim();
        n_rows = 0;
        // One source at a time, three-beat frames
        for (int s = 0; s < N_SOURCES; s++) begin
            for (int b = 0; b < 3; b++) add_row(PH_SRC, s, b == 2, RDY_ALL);
            add_row(PH_RUN, 0, 1'b0, RDY_ALL);
        end
        // All sources pending, two frames each
        for (int f = 0; f < 2; f++)
            for (int s = 0; s < N_SOURCES; s++)
                for (int b = 0; b < 2; b++) add_row(PH_SRC, s, b == 1, RDY_ALL);
        add_row(PH_RUN, 0, 1'b0, RDY_ALL);
        // Mixed frame lengths under back-pressure
        for (int f = 0; f < 2; f++)
            for (int s = 0; s < N_SOURCES; s++)
                for (int b = 0; b <= (f + s) % 3; b++)
                    add_row(PH_SRC, s, b == (f + s) % 3, RDY_ALL);
        add_row(PH_RUN, 0, 1'b0, RDY_RAND);
        // Return path routing by id
        for (int b = 0; b < 8; b++) add_row(PH_SER, b % 4, 1'b0, RDY_ALL);
        add_row(PH_RUN, 0, 1'b0, RDY_ALL);
        for (int b = 0; b < 12; b++) add_row(PH_SER, (b * 3 + 1) % 4, b[0], RDY_ALL);
        add_row(PH_RUN, 0, 1'b0, RDY_RAND);
        // Threshold ready with both outputs stalled
        for (int b = 0; b < 5; b++) add_row(PH_SER, b % 2, 1'b0, RDY_ALL);
        add_row(PH_RUN, 0, 1'b0, RDY_NONE);
        add_row(PH_CHK, 0, 1'b0, RDY_ALL);
        add_row(PH_RUN, 0, 1'b0, RDY_ALL);
        add_row(PH_CHK, 1, 1'b0, RDY_ALL);
    endtask

    // Round robin from base, whole frames, base moves past the winner
    task automatic predict_frames();
        int s;
        logic fin;
        axis_tagged_t t;
        while ((mdl_rd[0] != src_wr[0]) || (mdl_rd[1] != src_wr[1]) ||
               (mdl_rd[2] != src_wr[2])) begin
            s = mdl_base;
            while (mdl_rd[s] == src_wr[s]) s = (s + 1) % N_SOURCES;
            fin = 1'b0;
            while (!fin && (mdl_rd[s] != src_wr[s])) begin
                t.beat = src_mem[s][mdl_rd[s]];
                t.id   = stream_id_t'(s);
                exp_up_q.push_back(t);
                fin = t.beat.last;
                mdl_rd[s]++;
            end
            mdl_base = (s + 1) % N_SOURCES;
        end
    endtask

    task automatic check_dest(input int dst, input logic valid, input logic ready,
                              input axis_beat_t beat);
        axis_beat_t exp_b;
        string      name;
        name = (dst == 0) ? "up_out" : "aa_out";
        if (!valid && (beat !== '0)) begin
            err_dn++;
            $display("FAIL %s: got %h expected %h", name, beat, axis_beat_t'(0));
        end
        if (valid && ready) begin
            occ--;
            if (((dst == 0) ? exp_dn_up.size() : exp_dn_aa.size()) == 0) begin
                err_dn++;
                $display("Unexpected beat on %s", name);
            end else begin
                exp_b = (dst == 0) ? exp_dn_up.pop_front() : exp_dn_aa.pop_front();
                if (beat !== exp_b) begin
                    err_dn++;
                    $display("FAIL %s: got %h expected %h", name, beat, exp_b);
                end
            end
        end
    endtask

    task automatic sample_edge();
        axis_tagged_t t;
        if (is_in_ready !== (occ <= FIFO_TH)) begin
            err_rdy++;
            $display("FAIL is_in_ready: got %h expected %h", is_in_ready, occ <= FIFO_TH);
        end
        if ($countones({la_in_ready, aa_in_ready, up_in_ready}) > 1) begin
            err_up++;
            $display("More than one source sees ready at once");
        end
        if (up_in_valid && up_in_ready) src_rd[0]++;
        if (aa_in_valid && aa_in_ready) src_rd[1]++;
        if (la_in_valid && la_in_ready) src_rd[2]++;
        if (is_out_valid && is_out_ready) begin
            if (exp_up_q.size() == 0) begin
                err_up++;
                $display("Unexpected beat on is_out with no frame pending");
            end else begin
                t = exp_up_q.pop_front();
                if (is_out !== t) begin
                    err_up++;
                    $display("FAIL is_out: got %h expected %h", is_out, t);
                end
            end
        end
        if (is_in_valid && is_in_ready) begin
            t = ser_q.pop_front();
            if ((t.id == ID_UP) || (t.id == ID_AA)) occ++;
        end
        check_dest(0, up_out_valid, up_out_ready, up_out);
        check_dest(1, aa_out_valid, aa_out_ready, aa_out);
    endtask

    task automatic drive_inputs(input logic [1:0] mode);
        up_in_valid = (src_rd[0] != src_wr[0]);
        aa_in_valid = (src_rd[1] != src_wr[1]);
        la_in_valid = (src_rd[2] != src_wr[2]);
        up_in = src_head(0);
        aa_in = src_head(1);
        la_in = src_head(2);
        // Serdes stops sending while the FIFO asks for slack
        is_in_valid = (ser_q.size() != 0) && is_in_ready;
        is_in = (ser_q.size() != 0) ? ser_q[0] : '0;
        ready_value(mode, is_out_ready);
        ready_value(mode, up_out_ready);
        ready_value(mode, aa_out_ready);
    endtask

    function automatic logic phase_done(input logic [1:0] mode);
        logic up_idle;
        logic dn_idle;
        up_idle = (src_rd[0] == src_wr[0]) && (src_rd[1] == src_wr[1]) &&
                  (src_rd[2] == src_wr[2]) && (exp_up_q.size() == 0);
        dn_idle = (ser_q.size() == 0) &&
                  ((mode == RDY_NONE) || ((exp_dn_up.size() == 0) && (exp_dn_aa.size() == 0)));
        return up_idle && dn_idle;
    endfunction

    task automatic run_phase(input logic [1:0] mode);
        logic done;
        drive_inputs(mode);
        done = 1'b0;
        while (!done) begin
            @(posedge axis_clk);
            sample_edge();
            @(negedge axis_clk);
            drive_inputs(mode);
            done = phase_done(mode);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        axis_tagged_t t;
        row_t         row;
        axi_reset_n  = 1'b0;
        {up_in, aa_in, la_in, is_in} = '0;
        {up_in_valid, aa_in_valid, la_in_valid, is_in_valid} = '0;
        {is_out_ready, up_out_ready, aa_out_ready} = '0;
        for (int s = 0; s < N_SOURCES; s++) begin
            src_wr[s] = 0;
            src_rd[s] = 0;
            mdl_rd[s] = 0;
        end
        {mdl_base, occ, err_up, err_dn, err_rdy} = '0;
        lfsr = 32'hfa88;
        build_stim();
        max_cycles = n_rows * 40;
        repeat (10) @(negedge axis_clk);
        axi_reset_n = 1'b1;
        for (int r = 0; r < n_rows; r++) begin
            row = stim[r];
            case (row.phase)
                PH_SRC: begin
                    src_mem[row.sel][src_wr[row.sel]] = make_beat(row.data, row.last);
                    src_wr[row.sel]++;
                end
                PH_SER: begin
                    t.beat = make_beat(row.data, row.last);
                    t.id   = stream_id_t'(row.sel);
                    ser_q.push_back(t);
                    if (t.id == ID_UP) exp_dn_up.push_back(t.beat);
                    if (t.id == ID_AA) exp_dn_aa.push_back(t.beat);
                end
                PH_RUN: begin
                    predict_frames();
                    run_phase(row.rdy);
                end
                default: begin
                    if (is_in_ready !== row.sel[0]) begin
                        err_rdy++;
                        $display("FAIL is_in_ready: got %h expected %h", is_in_ready, row.sel[0]);
                    end
                end
            endcase
        end
        err_sva = axis_switch_inst.axis_switch_assertions_inst.fail_cnt;
        $display("Errors: upstream %0d, downstream %0d, ready %0d, assertions %0d",
                 err_up, err_dn, err_rdy, err_sva);
        if ((err_up + err_dn + err_rdy + err_sva) == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        cycle_cnt = 0;
        while ((max_cycles == 0) || (cycle_cnt <= max_cycles)) begin
            @(posedge axis_clk);
            cycle_cnt++;
        end
        $display("Timeout: run did not finish within %0d cycles", max_cycles);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== hdl/axis_switch.sv ====
`timescale 1ns/1ps

module axis_switch
    import axis_switch_pkg::*;
(
    input  logic         axis_clk,
    input  logic         axi_reset_n,

    // Upstream sources
    input  axis_beat_t   up_in,
    input  logic         up_in_valid,
    output logic         up_in_ready,
    input  axis_beat_t   aa_in,
    input  logic         aa_in_valid,
    output logic         aa_in_ready,
    input  axis_beat_t   la_in,
    input  logic         la_in_valid,
    output logic         la_in_ready,

    // Serdes side
    output axis_tagged_t is_out,
    output logic         is_out_valid,
    input  logic         is_out_ready,
    input  axis_tagged_t is_in,
    input  logic         is_in_valid,
    output logic         is_in_ready,

    // Downstream destinations
    output axis_beat_t   up_out,
    output logic         up_out_valid,
    input  logic         up_out_ready,
    output axis_beat_t   aa_out,
    output logic         aa_out_valid,
    input  logic         aa_out_ready
);

    grant_t       src_valid;
    grant_t       src_ready;
    grant_t       grant;
    logic         frame_done;
    axis_tagged_t head;
    logic         not_empty;
    logic         pop;

    ////////////////////////////////////////////////////////////
    // Upstream path
    ////////////////////////////////////////////////////////////

    assign src_valid = {la_in_valid, aa_in_valid, up_in_valid};

    assign up_in_ready = src_ready[0];
    assign aa_in_ready = src_ready[1];
    assign la_in_ready = src_ready[2];

    rr_arbiter rr_arbiter_inst (
        .axis_clk    (axis_clk),
        .axi_reset_n (axi_reset_n),
        .req         (src_valid),
        .frame_done  (frame_done),
        .grant       (grant)
    );

    upstream_mux upstream_mux_inst (
        .axis_clk     (axis_clk),
        .axi_reset_n  (axi_reset_n),
        .grant        (grant),
        .up_in        (up_in),
        .aa_in        (aa_in),
        .la_in        (la_in),
        .in_valid     (src_valid),
        .is_out_ready (is_out_ready),
        .in_ready     (src_ready),
        .is_out       (is_out),
        .is_out_valid (is_out_valid),
        .frame_done   (frame_done)
    );

    ////////////////////////////////////////////////////////////
    // Downstream path
    ////////////////////////////////////////////////////////////

    rx_fifo rx_fifo_inst (
        .axis_clk    (axis_clk),
        .axi_reset_n (axi_reset_n),
        .is_in       (is_in),
        .is_in_valid (is_in_valid),
        .pop         (pop),
        .is_in_ready (is_in_ready),
        .head        (head),
        .not_empty   (not_empty)
    );

    downstream_demux downstream_demux_inst (
        .head         (head),
        .not_empty    (not_empty),
        .up_out_ready (up_out_ready),
        .aa_out_ready (aa_out_ready),
        .pop          (pop),
        .up_out       (up_out),
        .aa_out       (aa_out),
        .up_out_valid (up_out_valid),
        .aa_out_valid (aa_out_valid)
    );

endmodule

// ==== hdl/axis_switch_pkg.sv ====
package axis_switch_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and sizes
    ////////////////////////////////////////////////////////////

    localparam int DATA_WIDTH      = 32;
    localparam int STRB_WIDTH      = 4;
    localparam int USER_WIDTH      = 2;
    localparam int ID_WIDTH        = 2;
    localparam int N_SOURCES       = 3;
    localparam int SRC_IDX_WIDTH   = 2;

    // Return path FIFO
    localparam int FIFO_DEPTH      = 8;
    localparam int FIFO_ADDR_WIDTH = 3;
    localparam int FIFO_TH         = 4;

    typedef logic [DATA_WIDTH-1:0]      data_t;
    typedef logic [STRB_WIDTH-1:0]      strb_t;
    typedef logic [USER_WIDTH-1:0]      user_t;
    typedef logic [ID_WIDTH-1:0]        stream_id_t;
    typedef logic [SRC_IDX_WIDTH-1:0]   src_idx_t;
    typedef logic [N_SOURCES-1:0]       grant_t;
    typedef logic [FIFO_ADDR_WIDTH:0]   fifo_count_t;

    // Downstream destinations
    localparam stream_id_t ID_UP = 2'd0;
    localparam stream_id_t ID_AA = 2'd1;

    ////////////////////////////////////////////////////////////
    // Stream beats
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        data_t data;
        strb_t strb;
        strb_t keep;
        logic  last;
        user_t user;
    } axis_beat_t;

    typedef struct packed {
        axis_beat_t beat;
        stream_id_t id;
    } axis_tagged_t;

    typedef enum logic {
        ARB_IDLE,
        ARB_FRAME
    } arb_state_t;

endpackage

// ==== hdl/downstream_demux.sv ====
`timescale 1ns/1ps

module downstream_demux
    import axis_switch_pkg::*;
(
    input  axis_tagged_t head,
    input  logic         not_empty,
    input  logic         up_out_ready,
    input  logic         aa_out_ready,
    output logic         pop,
    output axis_beat_t   up_out,
    output axis_beat_t   aa_out,
    output logic         up_out_valid,
    output logic         aa_out_valid
);

    logic to_up;
    logic to_aa;

    // Head id picks the destination
    assign to_up = not_empty && (head.id == ID_UP);
    assign to_aa = not_empty && (head.id == ID_AA);

    assign up_out_valid = to_up;
    assign aa_out_valid = to_aa;

    // Idle output reads zero
    assign up_out = to_up ? head.beat : '0;
    assign aa_out = to_aa ? head.beat : '0;

    assign pop = (to_up && up_out_ready) || (to_aa && aa_out_ready);

endmodule

// ==== hdl/rr_arbiter.sv ====
`timescale 1ns/1ps

module rr_arbiter
    import axis_switch_pkg::*;
(
    input  logic   axis_clk,
    input  logic   axi_reset_n,
    input  grant_t req,
    input  logic   frame_done,
    output grant_t grant
);

    arb_state_t state;
    src_idx_t   base_ptr;

    src_idx_t   cand;
    src_idx_t   pick_idx;
    logic       pick_found;

    // First requester at or after the base, wrapping upward
    always_comb begin
        cand       = base_ptr;
        pick_idx   = '0;
        pick_found = 1'b0;
        for (int i = 0; i < N_SOURCES; i++) begin
            if (!pick_found && req[cand]) begin
                pick_idx   = cand;
                pick_found = 1'b1;
            end
            if (cand == src_idx_t'(N_SOURCES - 1)) begin
                cand = '0;
            end else begin
                cand = cand + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Grant held from first beat to last beat
    ////////////////////////////////////////////////////////////

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            state    <= ARB_IDLE;
            grant    <= '0;
            base_ptr <= '0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (pick_found) begin
                        grant <= grant_t'(1) << pick_idx;
                        state <= ARB_FRAME;
                        // Next search starts past the winner
                        if (pick_idx == src_idx_t'(N_SOURCES - 1)) begin
                            base_ptr <= '0;
                        end else begin
                            base_ptr <= pick_idx + 1'b1;
                        end
                    end
                end
                ARB_FRAME: begin
                    if (frame_done) begin
                        grant <= '0;
                        state <= ARB_IDLE;
                    end
                end
                default: begin
                    grant <= '0;
                    state <= ARB_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== hdl/rx_fifo.sv ====
`timescale 1ns/1ps

module rx_fifo
    import axis_switch_pkg::*;
(
    input  logic         axis_clk,
    input  logic         axi_reset_n,
    input  axis_tagged_t is_in,
    input  logic         is_in_valid,
    input  logic         pop,
    output logic         is_in_ready,
    output axis_tagged_t head,
    output logic         not_empty
);

    axis_tagged_t mem [FIFO_DEPTH];

    fifo_count_t wr_ptr;
    fifo_count_t rd_ptr;
    fifo_count_t occupancy;

    logic full;
    logic empty;
    logic id_ok;
    logic wr_en;
    logic rd_en;

    // Extra top bit tells full from empty
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[FIFO_ADDR_WIDTH] != rd_ptr[FIFO_ADDR_WIDTH]) &&
                   (wr_ptr[FIFO_ADDR_WIDTH-1:0] == rd_ptr[FIFO_ADDR_WIDTH-1:0]);

    assign occupancy = wr_ptr - rd_ptr;

    // Early back-pressure leaves room for the serdes to stop
    assign is_in_ready = (occupancy <= fifo_count_t'(FIFO_TH));

    // Only ids with a destination are kept
    assign id_ok = (is_in.id == ID_UP) || (is_in.id == ID_AA);
    assign wr_en = is_in_valid && id_ok && !full;
    assign rd_en = pop && !empty;

    assign not_empty = !empty;
    assign head      = mem[rd_ptr[FIFO_ADDR_WIDTH-1:0]];

    ////////////////////////////////////////////////////////////
    // Storage and pointers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge axis_clk) begin
        if (wr_en) begin
            mem[wr_ptr[FIFO_ADDR_WIDTH-1:0]] <= is_in;
        end
    end

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// ==== hdl/upstream_mux.sv ====
`timescale 1ns/1ps

module upstream_mux
    import axis_switch_pkg::*;
(
    input  logic         axis_clk,
    input  logic         axi_reset_n,
    input  grant_t       grant,
    input  axis_beat_t   up_in,
    input  axis_beat_t   aa_in,
    input  axis_beat_t   la_in,
    input  grant_t       in_valid,
    input  logic         is_out_ready,
    output grant_t       in_ready,
    output axis_tagged_t is_out,
    output logic         is_out_valid,
    output logic         frame_done
);

    axis_beat_t src_beat [N_SOURCES];
    axis_beat_t sel_beat;
    src_idx_t   sel_idx;
    logic       sel_valid;
    logic       slot_free;
    logic       accept;

    assign src_beat[0] = up_in;
    assign src_beat[1] = aa_in;
    assign src_beat[2] = la_in;

    // One-hot select of the granted source
    always_comb begin
        sel_beat = '0;
        sel_idx  = '0;
        for (int i = 0; i < N_SOURCES; i++) begin
            if (grant[i]) begin
                sel_beat = src_beat[i];
                sel_idx  = src_idx_t'(i);
            end
        end
    end

    assign sel_valid = |(grant & in_valid);

    // Register can take a beat when empty or draining this cycle
    assign slot_free  = !is_out_valid || is_out_ready;
    assign in_ready   = grant & {N_SOURCES{slot_free}};
    assign accept     = sel_valid && slot_free;
    assign frame_done = accept && sel_beat.last;

    ////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            is_out_valid <= 1'b0;
        end else if (accept) begin
            is_out_valid <= 1'b1;
        end else if (is_out_ready) begin
            is_out_valid <= 1'b0;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (accept) begin
            is_out.beat <= sel_beat;
            // Source index becomes the stream id
            is_out.id   <= stream_id_t'(sel_idx);
        end
    end

endmodule

// ==== sources.f ====
hdl/axis_switch_pkg.sv
hdl/rr_arbiter.sv
hdl/upstream_mux.sv
hdl/rx_fifo.sv
hdl/downstream_demux.sv
hdl/axis_switch.sv
bench/axis_switch_assertions.sv
bench/axis_switch_tb.sv
